//--- Bender.yml
package:
  name: bus_map

sources:
  - design/bus_map_pkg.sv
  - design/host_port.sv
  - design/addr_mapper.sv
  - design/word_mem.sv
  - design/boot_rom.sv
  - design/gpio_regs.sv
  - design/bus_top.sv
  - target: test
    files:
      - verification/bus_checker.sv
      - verification/tb_top.sv

//--- design/addr_mapper.sv
/* address mapper */

module addr_mapper import bus_map_pkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        start,
        input  logic [31:0] acc_addr,
        input  logic [31:0] acc_wdata,
        input  logic [3:0]  acc_be,
        input  logic        acc_rd,
        input  logic        rom_ready,
        input  logic [31:0] rom_rdata,
        input  logic        ram_ready,
        input  logic [31:0] ram_rdata,
        input  logic [31:0] gpio_rdata,
        output logic        done,
        output logic [31:0] result,
        output logic        rom_rd,
        output logic [7:0]  rom_addr,
        output logic        ram_rd,
        output logic        ram_we,
        output logic [9:0]  ram_addr,
        output logic [31:0] ram_wdata,
        output logic [3:0]  ram_be,
        output logic        gpio_rd,
        output logic        gpio_we,
        output logic        gpio_addr,
        output logic [31:0] gpio_wdata,
        output logic [3:0]  gpio_be
);

        typedef enum logic [1:0] {
                st_idle,
                st_strobe,
                st_wait
        } map_state_t;

        typedef enum logic [1:0] {
                sel_none,
                sel_boot,
                sel_ram,
                sel_gpio
        } region_t;

        map_state_t  state;
        region_t     region;
        logic [31:0] addr_q;
        logic [31:0] wdata_q;
        logic [3:0]  be_q;
        logic        rd_q;
        logic        strobe;
        logic        use_ready;
        logic        dev_ready;
        logic [31:0] dev_rdata;

        always_comb begin
                case (addr_q[31:16])
                        region_boot: region = sel_boot;
                        region_ram:  region = sel_ram;
                        region_gpio: region = sel_gpio;
                        default:     region = sel_none;
                endcase
        end

        assign strobe = (state == st_strobe);

        // a ROM write gets no strobe and ends like an unmapped access
        assign use_ready = (region == sel_ram) || (region == sel_boot && rd_q);

        assign dev_ready = (region == sel_ram) ? ram_ready : rom_ready;
        assign dev_rdata = (region == sel_ram) ? ram_rdata : rom_rdata;

        // one-cycle strobes, only to the selected device
        assign rom_rd  = strobe && region == sel_boot && rd_q;
        assign ram_rd  = strobe && region == sel_ram && rd_q;
        assign ram_we  = strobe && region == sel_ram && !rd_q;
        assign gpio_rd = strobe && region == sel_gpio && rd_q;
        assign gpio_we = strobe && region == sel_gpio && !rd_q;

        // word indices
        assign rom_addr  = addr_q[$clog2(rom_words)+1:2];
        assign ram_addr  = addr_q[$clog2(ram_words)+1:2];
        assign gpio_addr = addr_q[2];

        assign ram_wdata  = wdata_q;
        assign ram_be     = be_q;
        assign gpio_wdata = wdata_q;
        assign gpio_be    = be_q;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= st_idle;
                        done  <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                                st_idle: begin
                                        if (start)
                                                state <= st_strobe;
                                end
                                st_strobe: begin
                                        if (use_ready) begin
                                                state <= st_wait;
                                        end else begin
                                                done  <= 1'b1;
                                                state <= st_idle;
                                        end
                                end
                                st_wait: begin
                                        if (dev_ready) begin
                                                done  <= 1'b1;
                                                state <= st_idle;
                                        end
                                end
                                default: state <= st_idle;
                        endcase
                end
        end

        // latched access and result register
        always_ff @(posedge clk) begin
                if (state == st_idle && start) begin
                        addr_q  <= acc_addr;
                        wdata_q <= acc_wdata;
                        be_q    <= acc_be;
                        rd_q    <= acc_rd;
                end
                if (strobe && !use_ready)
                        result <= (region == sel_gpio) ? gpio_rdata : err_word;
                if (state == st_wait && dev_ready)
                        result <= dev_rdata;
        end

endmodule

//--- design/boot_rom.sv
/* boot ROM */

module boot_rom import bus_map_pkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        rd,
        input  logic [7:0]  addr,
        output logic        ready,
        output logic [31:0] rdata
);

        always_ff @(posedge clk) begin
                if (rst)
                        ready <= 1'b0;
                else
                        ready <= rd;
        end

        // contents come straight from the index
        always_ff @(posedge clk) begin
                if (rd)
                        rdata <= rom_word(addr);
        end

endmodule

//--- design/bus_map_pkg.sv
/* bus address map definitions */

package bus_map_pkg;

        // upper address half-word of each region
        localparam logic [15:0] region_boot = 16'h1c00;
        localparam logic [15:0] region_ram  = 16'h1d00;
        localparam logic [15:0] region_gpio = 16'h9200;

        // returned for reads outside the map
        localparam logic [31:0] err_word = 32'hdeadbeef;

        // device sizes in words
        localparam int rom_words = 256;
        localparam int ram_words = 1024;

        // extra cycles before the RAM answers
        localparam int ram_wait = 2;

        // pin count of the GPIO block
        localparam int gpio_width = 16;

        // boot ROM contents, derived from the word index
        function automatic logic [31:0] rom_word(input logic [7:0] idx);
                logic [31:0] word;
                word[7:0]   = idx;
                word[15:8]  = ~idx;
                word[31:16] = 16'hb007;
                return word;
        endfunction

endpackage

//--- design/bus_top.sv
/* bus subsystem top */

module bus_top import bus_map_pkg::*; (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  req,
        input  logic [31:0]           addr,
        input  logic [31:0]           wdata,
        input  logic [3:0]            be,
        input  logic                  rd,
        input  logic [gpio_width-1:0] gpio_in,
        output logic                  ack,
        output logic [31:0]           rdata,
        output logic [gpio_width-1:0] gpio_out
);

        // host port to mapper
        logic        start;
        logic        done;
        logic [31:0] result;
        logic [31:0] acc_addr;
        logic [31:0] acc_wdata;
        logic [3:0]  acc_be;
        logic        acc_rd;

        // mapper to devices
        logic        rom_rd;
        logic [7:0]  rom_addr;
        logic        rom_ready;
        logic [31:0] rom_rdata;
        logic        ram_rd;
        logic        ram_we;
        logic [9:0]  ram_addr;
        logic [31:0] ram_wdata;
        logic [3:0]  ram_be;
        logic        ram_ready;
        logic [31:0] ram_rdata;
        logic        gpio_rd;
        logic        gpio_we;
        logic        gpio_addr;
        logic [31:0] gpio_wdata;
        logic [3:0]  gpio_be;
        logic [31:0] gpio_rdata;

        host_port host_port_inst (
                .clk       (clk),
                .rst       (rst),
                .req       (req),
                .addr      (addr),
                .wdata     (wdata),
                .be        (be),
                .rd        (rd),
                .done      (done),
                .result    (result),
                .ack       (ack),
                .rdata     (rdata),
                .start     (start),
                .acc_addr  (acc_addr),
                .acc_wdata (acc_wdata),
                .acc_be    (acc_be),
                .acc_rd    (acc_rd)
        );

        addr_mapper addr_mapper_inst (
                .clk        (clk),
                .rst        (rst),
                .start      (start),
                .acc_addr   (acc_addr),
                .acc_wdata  (acc_wdata),
                .acc_be     (acc_be),
                .acc_rd     (acc_rd),
                .rom_ready  (rom_ready),
                .rom_rdata  (rom_rdata),
                .ram_ready  (ram_ready),
                .ram_rdata  (ram_rdata),
                .gpio_rdata (gpio_rdata),
                .done       (done),
                .result     (result),
                .rom_rd     (rom_rd),
                .rom_addr   (rom_addr),
                .ram_rd     (ram_rd),
                .ram_we     (ram_we),
                .ram_addr   (ram_addr),
                .ram_wdata  (ram_wdata),
                .ram_be     (ram_be),
                .gpio_rd    (gpio_rd),
                .gpio_we    (gpio_we),
                .gpio_addr  (gpio_addr),
                .gpio_wdata (gpio_wdata),
                .gpio_be    (gpio_be)
        );

        word_mem #(
                .WAIT_STATES (ram_wait)
        ) word_mem_inst (
                .clk   (clk),
                .rst   (rst),
                .rd    (ram_rd),
                .we    (ram_we),
                .addr  (ram_addr),
                .wdata (ram_wdata),
                .be    (ram_be),
                .ready (ram_ready),
                .rdata (ram_rdata)
        );

        boot_rom boot_rom_inst (
                .clk   (clk),
                .rst   (rst),
                .rd    (rom_rd),
                .addr  (rom_addr),
                .ready (rom_ready),
                .rdata (rom_rdata)
        );

        // only the two low byte lanes reach the pins
        gpio_regs gpio_regs_inst (
                .clk      (clk),
                .rst      (rst),
                .rd       (gpio_rd),
                .we       (gpio_we),
                .addr     (gpio_addr),
                .wdata    (gpio_wdata),
                .be       (gpio_be[1:0]),
                .gpio_in  (gpio_in),
                .rdata    (gpio_rdata),
                .gpio_out (gpio_out)
        );

endmodule

//--- design/gpio_regs.sv
/* GPIO registers */

module gpio_regs import bus_map_pkg::*; (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  rd,
        input  logic                  we,
        input  logic                  addr,
        input  logic [31:0]           wdata,
        input  logic [1:0]            be,
        input  logic [gpio_width-1:0] gpio_in,
        output logic [31:0]           rdata,
        output logic [gpio_width-1:0] gpio_out
);

        logic [gpio_width-1:0] in_meta;
        logic [gpio_width-1:0] in_sync;
        logic [gpio_width-1:0] sel_word;

        // register 0, byte writable
        always_ff @(posedge clk) begin
                if (rst) begin
                        gpio_out <= '0;
                end else if (we && !addr) begin
                        if (be[0])
                                gpio_out[7:0] <= wdata[7:0];
                        if (be[1])
                                gpio_out[15:8] <= wdata[15:8];
                end
        end

        // two-flop synchronizer for the input pins
        always_ff @(posedge clk) begin
                in_meta <= gpio_in;
                in_sync <= in_meta;
        end

        assign sel_word = addr ? in_sync : gpio_out;
        assign rdata    = rd ? {{(32 - gpio_width){1'b0}}, sel_word} : '0;

endmodule

//--- design/host_port.sv
/* four-phase host port */

module host_port (
        input  logic        clk,
        input  logic        rst,
        input  logic        req,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        input  logic [3:0]  be,
        input  logic        rd,
        input  logic        done,
        input  logic [31:0] result,
        output logic        ack,
        output logic [31:0] rdata,
        output logic        start,
        output logic [31:0] acc_addr,
        output logic [31:0] acc_wdata,
        output logic [3:0]  acc_be,
        output logic        acc_rd
);

        typedef enum logic [1:0] {
                hp_idle,
                hp_busy,
                hp_ack
        } hp_state_t;

        hp_state_t state;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= hp_idle;
                        start <= 1'b0;
                        ack   <= 1'b0;
                end else begin
                        start <= 1'b0;
                        case (state)
                                hp_idle: begin
                                        // ack is low here, so a new request is legal
                                        if (req) begin
                                                start <= 1'b1;
                                                state <= hp_busy;
                                        end
                                end
                                hp_busy: begin
                                        if (done) begin
                                                ack   <= 1'b1;
                                                state <= hp_ack;
                                        end
                                end
                                hp_ack: begin
                                        // return to zero
                                        if (!req) begin
                                                ack   <= 1'b0;
                                                state <= hp_idle;
                                        end
                                end
                                default: state <= hp_idle;
                        endcase
                end
        end

        // access fields and read result
        always_ff @(posedge clk) begin
                if (state == hp_idle && req) begin
                        acc_addr  <= addr;
                        acc_wdata <= wdata;
                        acc_be    <= be;
                        acc_rd    <= rd;
                end
                if (state == hp_busy && done)
                        rdata <= result;
        end

endmodule

//--- design/word_mem.sv
/* RAM with byte enables and wait states */

module word_mem import bus_map_pkg::*; #(
        parameter int WAIT_STATES = ram_wait
) (
        input  logic        clk,
        input  logic        rst,
        input  logic        rd,
        input  logic        we,
        input  logic [9:0]  addr,
        input  logic [31:0] wdata,
        input  logic [3:0]  be,
        output logic        ready,
        output logic [31:0] rdata
);

        localparam int cnt_w = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

        logic [31:0]      mem [ram_words];
        logic [cnt_w-1:0] cnt;
        logic             strobe;
        logic             fire;

        assign strobe = rd || we;

        // last wait cycle, or the strobe itself when there are none
        assign fire = (WAIT_STATES == 0) ? strobe : (cnt == cnt_w'(1));

        always_ff @(posedge clk) begin
                if (rst) begin
                        cnt   <= '0;
                        ready <= 1'b0;
                end else begin
                        ready <= fire;
                        if (strobe)
                                cnt <= cnt_w'(WAIT_STATES);
                        else if (cnt != '0)
                                cnt <= cnt - cnt_w'(1);
                end
        end

        always_ff @(posedge clk) begin
                if (we) begin
                        for (int i = 0; i < 4; i++) begin
                                if (be[i])
                                        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                        end
                end
                // address is held by the mapper until ready
                if (fire)
                        rdata <= mem[addr];
        end

endmodule

//--- sources.f
design/bus_map_pkg.sv
design/host_port.sv
design/addr_mapper.sv
design/word_mem.sv
design/boot_rom.sv
design/gpio_regs.sv
design/bus_top.sv
verification/bus_checker.sv
verification/tb_top.sv

//--- verification/bus_checker.sv
/* bus access checker */

module bus_checker import bus_map_pkg::*; (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  req,
        input  logic [31:0]           addr,
        input  logic [31:0]           wdata,
        input  logic [3:0]            be,
        input  logic                  rd,
        input  logic                  ack,
        input  logic [31:0]           rdata,
        input  logic [gpio_width-1:0] gpio_in,
        input  logic [gpio_width-1:0] gpio_out,
        output int                    err_count
);

        logic [31:0]           ram_model [ram_words];
        logic [gpio_width-1:0] gpio_model;
        logic [31:0]           exp_word;
        logic                  prev_ack;
        logic                  prev_req;
        logic                  prev_rst;
        int                    pass_count;
        int                    test_checks;
        int                    test_errs;

        initial begin
                err_count   = 0;
                pass_count  = 0;
                test_checks = 0;
                test_errs   = 0;
                gpio_model  = '0;
                prev_ack    = 1'b0;
                prev_req    = 1'b0;
                prev_rst    = 1'b1;
        end

        // expected read word from the current model state
        function automatic logic [31:0] expected_read(input logic [31:0] a);
                logic [31:0] word;
                case (a[31:16])
                        region_boot: word = rom_word(a[9:2]);
                        region_ram:  word = ram_model[a[11:2]];
                        region_gpio: word = a[2] ? 32'(gpio_in) : 32'(gpio_model);
                        default:     word = err_word;
                endcase
                return word;
        endfunction

        task automatic apply_write(input logic [31:0] a, input logic [31:0] d,
                                   input logic [3:0] b);
                case (a[31:16])
                        region_ram: begin
                                for (int i = 0; i < 4; i++) begin
                                        if (b[i])
                                                ram_model[a[11:2]][i*8 +: 8] = d[i*8 +: 8];
                                end
                        end
                        region_gpio: begin
                                // only register 0 is writable, two lanes wide
                                if (!a[2]) begin
                                        if (b[0])
                                                gpio_model[7:0] = d[7:0];
                                        if (b[1])
                                                gpio_model[15:8] = d[15:8];
                                end
                        end
                        default: ;
                endcase
        endtask

        task automatic tally(input logic ok);
                test_checks++;
                if (ok) begin
                        pass_count++;
                end else begin
                        err_count++;
                        test_errs++;
                end
        endtask

        task automatic end_test(input string name);
                if (test_errs == 0)
                        $display("test %s passed, %0d checks", name, test_checks);
                else
                        $display("test %s FAILED, %0d of %0d checks wrong", name, test_errs,
                                 test_checks);
                test_checks = 0;
                test_errs   = 0;
        endtask

        task automatic final_counts();
                $display("checks passed %0d, failed %0d", pass_count, err_count);
        endtask

        always @(posedge clk) begin
                if (prev_rst && !rst) begin
                        if (ack !== 1'b0 || gpio_out !== '0) begin
                                $display("ERR %0t: ack %b gpio_out %h after reset", $time, ack,
                                         gpio_out);
                                tally(1'b0);
                        end else begin
                                tally(1'b1);
                        end
                end
                // ack just rose, so rdata is valid and the access is complete
                if (!rst && !prev_ack && ack) begin
                        if (!prev_req)
                                $display("ack rose at time %0t while req was low", $time);
                        tally(prev_req);
                        if (rd) begin
                                exp_word = expected_read(addr);
                                if (rdata !== exp_word) begin
                                        $display("ERR %0t: read of %h returned %h, expected %h",
                                                 $time, addr, rdata, exp_word);
                                        tally(1'b0);
                                end else begin
                                        tally(1'b1);
                                end
                        end else begin
                                apply_write(addr, wdata, be);
                        end
                        if (gpio_out !== gpio_model) begin
                                $display("ERR %0t: gpio_out is %h, expected %h", $time, gpio_out,
                                         gpio_model);
                                tally(1'b0);
                        end else begin
                                tally(1'b1);
                        end
                end
                if (!rst && prev_ack && !ack) begin
                        if (prev_req)
                                $display("ack fell at time %0t before req had fallen", $time);
                        tally(!prev_req);
                end
                prev_ack <= ack;
                prev_req <= req;
                prev_rst <= rst;
        end

endmodule

//--- verification/tb_top.sv
/* bus subsystem testbench */

module tb_top import bus_map_pkg::*; ();

        logic                  clk;
        logic                  rst;
        logic                  req;
        logic [31:0]           addr;
        logic [31:0]           wdata;
        logic [3:0]            be;
        logic                  rd;
        logic [gpio_width-1:0] gpio_in;
        logic                  ack;
        logic [31:0]           rdata;
        logic [gpio_width-1:0] gpio_out;
        int                    err_count;
        logic [31:0]           lcg_state;
        logic                  hung;

        bus_top bus_top_inst (
                .clk      (clk),
                .rst      (rst),
                .req      (req),
                .addr     (addr),
                .wdata    (wdata),
                .be       (be),
                .rd       (rd),
                .gpio_in  (gpio_in),
                .ack      (ack),
                .rdata    (rdata),
                .gpio_out (gpio_out)
        );

        bus_checker bus_checker_inst (
                .clk       (clk),
                .rst       (rst),
                .req       (req),
                .addr      (addr),
                .wdata     (wdata),
                .be        (be),
                .rd        (rd),
                .ack       (ack),
                .rdata     (rdata),
                .gpio_in   (gpio_in),
                .gpio_out  (gpio_out),
                .err_count (err_count)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // upper bits of the LCG state are the better ones
        function automatic logic [15:0] next_rand();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state[31:16];
        endfunction

        function automatic logic [31:0] make_addr(input logic [15:0] upper, input int idx);
                return {upper, 16'h0000} | (32'(idx) << 2);
        endfunction

        // upper half-words that hit no region
        function automatic logic [15:0] unmapped_upper(input logic [1:0] k);
                logic [15:0] upper;
                case (k)
                        2'd0:    upper = 16'h0000;
                        2'd1:    upper = 16'h1c01;
                        2'd2:    upper = 16'h9201;
                        default: upper = 16'hffff;
                endcase
                return upper;
        endfunction

        task automatic finish_run();
                bus_checker_inst.final_counts();
                if (err_count == 0 && !hung)
                        $display("No errors");
                else
                        $display("Errors found");
                $finish;
        endtask

        task automatic wait_ack(input logic level, input logic [31:0] a);
                int n;
                n = 0;
                while (ack !== level && n < 64) begin
                        @(negedge clk);
                        n++;
                end
                if (ack !== level) begin
                        $display("timeout: ack never went %0b during the access to %h", level, a);
                        hung = 1'b1;
                        finish_run();
                end
        endtask

        // one complete four-phase access
        task automatic run_access(input logic [31:0] a, input logic [31:0] d,
                                  input logic [3:0] b, input logic r);
                @(negedge clk);
                addr  = a;
                wdata = d;
                be    = b;
                rd    = r;
                req   = 1'b1;
                wait_ack(1'b1, a);
                req = 1'b0;
                wait_ack(1'b0, a);
                // the checker sees the fall of ack on the next rising edge
                @(negedge clk);
        endtask

        task automatic write_word(input logic [31:0] a, input logic [31:0] d,
                                  input logic [3:0] b);
                run_access(a, d, b, 1'b0);
        endtask

        task automatic read_word(input logic [31:0] a);
                run_access(a, 32'h0, 4'h0, 1'b1);
        endtask

        task automatic random_access();
                logic [31:0] a;
                logic [3:0]  b;
                logic        r;
                case (next_rand() % 4)
                        0:       a = make_addr(region_ram, next_rand() % 16);
                        1:       a = make_addr(region_boot, next_rand() % 256);
                        2:       a = make_addr(region_gpio, next_rand() % 2);
                        default: a = make_addr(unmapped_upper(2'(next_rand())), next_rand() % 16);
                endcase
                r = (next_rand() % 2) == 1;
                b = 4'(next_rand());
                if (b == 4'h0)
                        b = 4'hf;
                run_access(a, {next_rand(), next_rand()}, r ? 4'h0 : b, r);
        endtask

        initial begin : stimulus
                int          i;
                logic [3:0]  b;
                int          idx;
                lcg_state = 32'd40154;
                hung      = 1'b0;
                rst       = 1'b1;
                req       = 1'b0;
                addr      = '0;
                wdata     = '0;
                be        = '0;
                rd        = 1'b0;
                gpio_in   = '0;
                repeat (3) @(negedge clk);
                rst = 1'b0;
                repeat (2) @(negedge clk);
                bus_checker_inst.end_test("reset");

                // fill 16 RAM words, then merge partial writes into them
                for (i = 0; i < 16; i++)
                        write_word(make_addr(region_ram, i), {next_rand(), next_rand()}, 4'hf);
                for (i = 0; i < 16; i++) begin
                        b = 4'(next_rand());
                        if (b == 4'h0)
                                b = 4'h5;
                        write_word(make_addr(region_ram, next_rand() % 16),
                                   {next_rand(), next_rand()}, b);
                end
                for (i = 0; i < 16; i++)
                        read_word(make_addr(region_ram, i));
                bus_checker_inst.end_test("ram");

                for (i = 0; i < 16; i++)
                        read_word(make_addr(region_boot, next_rand() % 256));
                idx = next_rand() % 256;
                write_word(make_addr(region_boot, idx), 32'h0, 4'hf);
                read_word(make_addr(region_boot, idx));
                bus_checker_inst.end_test("rom");

                // upper lanes only must leave the pins alone
                write_word(make_addr(region_gpio, 0), {next_rand(), next_rand()}, 4'h1);
                read_word(make_addr(region_gpio, 0));
                write_word(make_addr(region_gpio, 0), {next_rand(), next_rand()}, 4'h2);
                read_word(make_addr(region_gpio, 0));
                write_word(make_addr(region_gpio, 0), {next_rand(), next_rand()}, 4'hc);
                read_word(make_addr(region_gpio, 0));
                gpio_in = 16'ha5c3;
                repeat (4) @(negedge clk);
                read_word(make_addr(region_gpio, 1));
                bus_checker_inst.end_test("gpio");

                for (i = 0; i < 4; i++)
                        read_word(make_addr(unmapped_upper(2'(i)), next_rand() % 16));
                for (i = 0; i < 4; i++)
                        write_word(make_addr(unmapped_upper(2'(i)), i), 32'h0, 4'hf);
                for (i = 0; i < 4; i++)
                        read_word(make_addr(region_ram, i));
                read_word(make_addr(region_gpio, 0));
                bus_checker_inst.end_test("unmapped");

                for (i = 0; i < 200; i++) begin
                        random_access();
                        repeat (next_rand() % 4) @(negedge clk);
                end
                bus_checker_inst.end_test("random");

                finish_run();
        end

endmodule
